//--- common/fv_info_defines.svh
`ifndef FV_INFO_DEFINES_SVH
`define FV_INFO_DEFINES_SVH

// Edge PE count and its tag width, log2 of the count.
`define FV_NUM_EDGE_PE 4
`define FV_PE_TAG_W 2

// Node id, also the info SRAM address.
`define FV_NODE_ID_W 8

// Feature-vector address fields.
`define FV_LINE_W 8
`define FV_OFFSET_W 4
`define FV_ADDR_W (`FV_LINE_W + `FV_OFFSET_W)

// Request FIFO depth, equal to the initial input credits.
`define FV_NODE_FIFO_DEPTH 8

// Result FIFO depth.
`define FV_OUT_FIFO_DEPTH 8

// Credits granted by the downstream consumer at reset.
`define FV_OUT_CREDITS 4

`endif

//--- common/fv_info_pkg.sv
`default_nettype none

`include "fv_info_defines.svh"

package fv_info_pkg;

    // Request fields.
    typedef logic [`FV_NODE_ID_W-1:0] node_id_t;
    typedef logic [`FV_PE_TAG_W-1:0]  pe_tag_t;

    // Result fields.
    typedef logic [`FV_LINE_W-1:0]   fv_line_t;
    typedef logic [`FV_OFFSET_W-1:0] fv_offset_t;

    // Line in the upper bits, offset in the lower.
    typedef struct packed {
        fv_line_t   line;
        fv_offset_t offset;
    } fv_fields_t;

    // One info word, flat as stored or split into line and offset.
    typedef union packed {
        logic [`FV_ADDR_W-1:0] raw;
        fv_fields_t            fields;
    } fv_addr_u;

endpackage

`default_nettype wire

//--- verilog/node_req_fifo.sv
`default_nettype none

`include "fv_info_defines.svh"

module node_req_fifo
    import fv_info_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     req_valid,
    input  wire node_id_t req_node_id,
    input  wire pe_tag_t  req_pe_tag,
    input  wire logic     pop,
    output logic          empty,
    output logic          req_out_valid,
    output node_id_t      req_out_node_id,
    output pe_tag_t       req_out_pe_tag,
    output logic          req_credit
);

    localparam int depth = `FV_NODE_FIFO_DEPTH;
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    node_id_t id_mem [depth];
    pe_tag_t  tag_mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Requester only sends with a credit in hand, so there is always room.
    assign do_push = req_valid;
    assign empty   = (count == '0);
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            req_out_valid <= 1'b0;
            req_credit    <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + ptr_w'(1);
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + ptr_w'(1);
            end
            count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
            // One slot freed per pop.
            req_out_valid <= do_pop;
            req_credit    <= do_pop;
        end
    end

    // Entry storage and the registered head.
    always_ff @(posedge clk) begin
        if (do_push) begin
            id_mem[wr_ptr]  <= req_node_id;
            tag_mem[wr_ptr] <= req_pe_tag;
        end
        if (do_pop) begin
            req_out_node_id <= id_mem[rd_ptr];
            req_out_pe_tag  <= tag_mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- fv_info_mem/fv_info_memcntl.sv
`default_nettype none

module fv_info_memcntl
    import fv_info_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     empty,
    input  wire logic     req_out_valid,
    input  wire node_id_t req_out_node_id,
    input  wire pe_tag_t  req_out_pe_tag,
    input  wire fv_addr_u sram_rdata,
    input  wire logic     almost_full,
    output logic          pop,
    output node_id_t      sram_addr,
    output logic          sram_cen,
    output logic          push,
    output fv_addr_u      push_fv_addr,
    output pe_tag_t       push_pe_tag
);

    localparam logic st_idle  = 1'b0;
    localparam logic st_fetch = 1'b1;

    logic     state;
    logic     nx_state;
    node_id_t nx_sram_addr;
    logic     nx_sram_cen;
    pe_tag_t  tag_q;
    pe_tag_t  nx_tag;
    logic     nx_push;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            sram_cen <= 1'b1;
            push     <= 1'b0;
        end else begin
            state    <= nx_state;
            sram_cen <= nx_sram_cen;
            push     <= nx_push;
        end
    end

    // Address, held tag and result word.
    always_ff @(posedge clk) begin
        sram_addr <= nx_sram_addr;
        tag_q     <= nx_tag;
        if (nx_push) begin
            push_fv_addr <= sram_rdata;
            push_pe_tag  <= tag_q;
        end
    end

    // Only one lookup in flight at a time.
    always_comb begin
        nx_state     = state;
        nx_sram_addr = sram_addr;
        nx_sram_cen  = 1'b1;
        nx_tag       = tag_q;
        nx_push      = 1'b0;
        pop          = 1'b0;

        case (state)
            st_idle: begin
                if (req_out_valid) begin
                    // Read only, the SRAM port is never written from here.
                    nx_sram_addr = req_out_node_id;
                    nx_sram_cen  = 1'b0;
                    nx_tag       = req_out_pe_tag;
                    nx_state     = st_fetch;
                end else if (!empty && !almost_full) begin
                    pop = 1'b1;
                end
            end
            st_fetch: begin
                // Read data is valid while the registered cen is low.
                nx_push  = 1'b1;
                nx_state = st_idle;
            end
            default: begin
                nx_state = st_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- fv_info_mem/fv_info_sram.sv
`default_nettype none

`include "fv_info_defines.svh"

module fv_info_sram
    import fv_info_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     load_en,
    input  wire node_id_t load_addr,
    input  wire fv_addr_u load_data,
    input  wire node_id_t sram_addr,
    input  wire logic     sram_cen,
    output fv_addr_u      sram_rdata
);

    localparam int words = 1 << `FV_NODE_ID_W;

    // One feature-vector address per node id.
    fv_addr_u mem [words];

    logic rd_en;

    // Load port has priority over a read.
    assign rd_en = !sram_cen && !load_en;

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr].raw <= load_data.raw;
        end
    end

    // Flow-through read, zero while deselected.
    always_comb begin
        sram_rdata.raw = '0;
        if (rd_en) begin
            sram_rdata.raw = mem[sram_addr].raw;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fv_out_fifo.sv
`default_nettype none

`include "fv_info_defines.svh"

module fv_out_fifo
    import fv_info_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     push,
    input  wire fv_addr_u push_fv_addr,
    input  wire pe_tag_t  push_pe_tag,
    input  wire logic     out_credit,
    output logic          almost_full,
    output logic          out_valid,
    output fv_addr_u      out_fv_addr,
    output pe_tag_t       out_pe_tag
);

    localparam int depth = `FV_OUT_FIFO_DEPTH;
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);
    localparam int crd_w = $clog2(`FV_OUT_CREDITS + 1);

    fv_addr_u addr_mem [depth];
    pe_tag_t  tag_mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic [crd_w-1:0] credits;
    logic             send;
    fv_addr_u         head_fv_addr;
    pe_tag_t          head_pe_tag;

    // Leaves room for the push already in flight.
    assign almost_full = (count >= cnt_w'(depth - 1));

    // Empty FIFO passes a push straight to the output register.
    assign head_fv_addr = (count == '0) ? push_fv_addr : addr_mem[rd_ptr];
    assign head_pe_tag  = (count == '0) ? push_pe_tag : tag_mem[rd_ptr];
    assign send         = (credits != '0) && ((count != '0) || push);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credits   <= crd_w'(`FV_OUT_CREDITS);
            out_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + ptr_w'(1);
            end
            if (send) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + ptr_w'(1);
            end
            count     <= count + cnt_w'(push) - cnt_w'(send);
            // Spend one per send, regain one per returned credit.
            credits   <= credits - crd_w'(send) + crd_w'(out_credit);
            out_valid <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= push_fv_addr;
            tag_mem[wr_ptr]  <= push_pe_tag;
        end
        if (send) begin
            out_fv_addr <= head_fv_addr;
            out_pe_tag  <= head_pe_tag;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fv_info_top.sv
`default_nettype none

module fv_info_top
    import fv_info_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     req_valid,
    input  wire node_id_t req_node_id,
    input  wire pe_tag_t  req_pe_tag,
    input  wire logic     out_credit,
    input  wire logic     load_en,
    input  wire node_id_t load_addr,
    input  wire fv_addr_u load_data,
    output logic          req_credit,
    output logic          out_valid,
    output fv_addr_u      out_fv_addr,
    output pe_tag_t       out_pe_tag
);

    // Request FIFO to controller.
    logic     empty;
    logic     pop;
    logic     req_out_valid;
    node_id_t req_out_node_id;
    pe_tag_t  req_out_pe_tag;

    // Controller to SRAM.
    node_id_t sram_addr;
    logic     sram_cen;
    fv_addr_u sram_rdata;

    // Controller to result FIFO.
    logic     almost_full;
    logic     push;
    fv_addr_u push_fv_addr;
    pe_tag_t  push_pe_tag;

    node_req_fifo u_node_req_fifo (
        .clk             (clk),
        .reset           (reset),
        .req_valid       (req_valid),
        .req_node_id     (req_node_id),
        .req_pe_tag      (req_pe_tag),
        .pop             (pop),
        .empty           (empty),
        .req_out_valid   (req_out_valid),
        .req_out_node_id (req_out_node_id),
        .req_out_pe_tag  (req_out_pe_tag),
        .req_credit      (req_credit)
    );

    fv_info_memcntl u_fv_info_memcntl (
        .clk             (clk),
        .reset           (reset),
        .empty           (empty),
        .req_out_valid   (req_out_valid),
        .req_out_node_id (req_out_node_id),
        .req_out_pe_tag  (req_out_pe_tag),
        .sram_rdata      (sram_rdata),
        .almost_full     (almost_full),
        .pop             (pop),
        .sram_addr       (sram_addr),
        .sram_cen        (sram_cen),
        .push            (push),
        .push_fv_addr    (push_fv_addr),
        .push_pe_tag     (push_pe_tag)
    );

    fv_info_sram u_fv_info_sram (
        .clk        (clk),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .sram_addr  (sram_addr),
        .sram_cen   (sram_cen),
        .sram_rdata (sram_rdata)
    );

    fv_out_fifo u_fv_out_fifo (
        .clk          (clk),
        .reset        (reset),
        .push         (push),
        .push_fv_addr (push_fv_addr),
        .push_pe_tag  (push_pe_tag),
        .out_credit   (out_credit),
        .almost_full  (almost_full),
        .out_valid    (out_valid),
        .out_fv_addr  (out_fv_addr),
        .out_pe_tag   (out_pe_tag)
    );

endmodule

`default_nettype wire

//--- sim/fv_info_props.sv
`default_nettype none

`include "fv_info_defines.svh"

module fv_info_props (
    input wire logic clk,
    input wire logic reset,
    input wire logic out_valid,
    input wire logic out_credit,
    input wire logic pop,
    input wire logic almost_full,
    input wire logic push,
    input wire logic sram_cen,
    input wire logic req_credit
);

    // Downstream credits seen from the ports.
    int credits_held;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits_held <= `FV_OUT_CREDITS;
        end else begin
            credits_held <= credits_held - int'(out_valid) + int'(out_credit);
        end
    end

    // A send in the previous cycle could not yet use that cycle's returned credit.
    out_valid_needs_credit: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> (credits_held - int'($past(out_credit))) > 0)
        else $error("out_valid sent with no downstream credit left");

    // A pop always lands as a push three cycles later.
    pop_not_when_almost_full: assert property (@(posedge clk) disable iff (reset)
        pop |-> !almost_full ##3 push)
        else $error("pop while the result FIFO is almost full, or no push three cycles later");

    push_after_read: assert property (@(posedge clk) disable iff (reset)
        push |-> $past(!sram_cen))
        else $error("push without an SRAM read in the cycle before");

    no_credit_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !req_credit)
        else $error("req_credit pulsed in the first cycle after reset");

endmodule

bind fv_info_top fv_info_props u_fv_info_props (
    .clk         (clk),
    .reset       (reset),
    .out_valid   (out_valid),
    .out_credit  (out_credit),
    .pop         (pop),
    .almost_full (almost_full),
    .push        (push),
    .sram_cen    (sram_cen),
    .req_credit  (req_credit)
);

`default_nettype wire

//--- sim/fv_info_tb.sv
`default_nettype none

`include "fv_info_defines.svh"

module fv_info_tb
    import fv_info_pkg::*;
();

    localparam int timeout_cycles = 200;
    localparam int quiet_cycles   = 60;

    logic     clk;
    logic     reset;
    logic     req_valid;
    node_id_t req_node_id;
    pe_tag_t  req_pe_tag;
    logic     out_credit;
    logic     load_en;
    node_id_t load_addr;
    fv_addr_u load_data;
    logic     req_credit;
    logic     out_valid;
    fv_addr_u out_fv_addr;
    pe_tag_t  out_pe_tag;

    node_id_t load_ids [$];
    fv_addr_u load_words [$];
    node_id_t req_ids [$];
    pe_tag_t  req_tags [$];
    fv_addr_u exp_words [$];
    pe_tag_t  exp_tags [$];

    int value_errors;
    int protocol_errors;
    int timeouts;
    int in_credits;
    int sent_count;
    int result_count;
    int credit_pulses;
    bit stop_run;

    fv_info_top dut (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_node_id (req_node_id),
        .req_pe_tag  (req_pe_tag),
        .out_credit  (out_credit),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .req_credit  (req_credit),
        .out_valid   (out_valid),
        .out_fv_addr (out_fv_addr),
        .out_pe_tag  (out_pe_tag)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic compare_fv_addr(input fv_addr_u got, input fv_addr_u exp);
        if (got.fields.line !== exp.fields.line) begin
            value_errors++;
            $display("FAIL %0t: line %h, expected %h", $time, got.fields.line, exp.fields.line);
        end
        if (got.fields.offset !== exp.fields.offset) begin
            value_errors++;
            $display("FAIL %0t: offset %h, expected %h", $time, got.fields.offset,
                     exp.fields.offset);
        end
    endtask

    task automatic compare_pe_tag(input pe_tag_t got, input pe_tag_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %0t: PE tag %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic read_golden();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        fv_addr_u    word;
        fd = $fopen("sim/fv_info_golden.txt", "r");
        if (fd == 0) begin
            protocol_errors++;
            stop_run = 1'b1;
            $display("Could not open sim/fv_info_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    kind = line[0];
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                    word.raw = b[`FV_ADDR_W-1:0];
                    case (kind)
                        "L": begin
                            load_ids.push_back(node_id_t'(a));
                            load_words.push_back(word);
                        end
                        "R": begin
                            req_ids.push_back(node_id_t'(a));
                            req_tags.push_back(pe_tag_t'(b));
                        end
                        "E": begin
                            word.raw = a[`FV_ADDR_W-1:0];
                            exp_words.push_back(word);
                            exp_tags.push_back(pe_tag_t'(b));
                        end
                        default: begin
                            protocol_errors++;
                            $display("Unknown record in golden file: %s", line);
                        end
                    endcase
                end
            end
            $fclose(fd);
            if (exp_words.size() != req_ids.size()) begin
                protocol_errors++;
                stop_run = 1'b1;
                $display("Golden file has %0d requests but %0d expected results",
                         req_ids.size(), exp_words.size());
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_request(input node_id_t id, input pe_tag_t tag);
        int waited;
        waited = 0;
        while (in_credits == 0 && waited < timeout_cycles) begin
            idle_cycles(1);
            waited++;
        end
        if (in_credits == 0) begin
            timeouts++;
            stop_run = 1'b1;
            $display("Timed out at %0t waiting for an input credit", $time);
        end else begin
            req_valid   = 1'b1;
            req_node_id = id;
            req_pe_tag  = tag;
            in_credits--;
            sent_count++;
            idle_cycles(1);
            req_valid = 1'b0;
        end
    endtask

    task automatic wait_results(input int target);
        int waited;
        waited = 0;
        while (result_count < target && waited < timeout_cycles) begin
            idle_cycles(1);
            waited++;
        end
        if (result_count < target) begin
            timeouts++;
            stop_run = 1'b1;
            $display("Timed out at %0t waiting for result %0d, only %0d arrived",
                     $time, target, result_count);
        end
    endtask

    // Samples on the falling edge, away from the DUT's register updates.
    always @(negedge clk) begin
        if (!reset) begin
            if (req_credit) begin
                credit_pulses++;
                in_credits++;
            end
            if (out_valid) begin
                result_count++;
                if (exp_words.size() == 0) begin
                    protocol_errors++;
                    $display("Extra result at %0t with no request left to match", $time);
                end else begin
                    compare_fv_addr(out_fv_addr, exp_words.pop_front());
                    compare_pe_tag(out_pe_tag, exp_tags.pop_front());
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hff8f));
        reset           = 1'b1;
        req_valid       = 1'b0;
        req_node_id     = '0;
        req_pe_tag      = '0;
        out_credit      = 1'b0;
        load_en         = 1'b0;
        load_addr       = '0;
        load_data       = '0;
        value_errors    = 0;
        protocol_errors = 0;
        timeouts        = 0;
        in_credits      = `FV_NODE_FIFO_DEPTH;
        sent_count      = 0;
        result_count    = 0;
        credit_pulses   = 0;
        stop_run        = 1'b0;
        read_golden();

        // Fill the info SRAM while reset is held.
        idle_cycles(1);
        for (int i = 0; i < load_ids.size(); i++) begin
            load_en   = 1'b1;
            load_addr = load_ids[i];
            load_data = load_words[i];
            idle_cycles(1);
        end
        load_en = 1'b0;
        idle_cycles(15 - load_ids.size());
        reset = 1'b0;

        // Quiet outputs after reset.
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (out_valid || req_credit) begin
                protocol_errors++;
                $display("Output active at %0t with no stimulus after reset", $time);
            end
        end
        idle_cycles(1);

        // All requests go in while downstream credits are withheld.
        for (int i = 0; i < req_ids.size() && !stop_run; i++) begin
            idle_cycles($urandom_range(3));
            send_request(req_ids[i], req_tags[i]);
        end
        if (!stop_run) begin
            wait_results(`FV_OUT_CREDITS);
        end
        if (!stop_run) begin
            idle_cycles(quiet_cycles);
            if (result_count != `FV_OUT_CREDITS) begin
                protocol_errors++;
                $display("%0d results went out on %0d initial credits",
                         result_count, `FV_OUT_CREDITS);
            end
        end

        // Returned credits release the rest one by one.
        for (int i = `FV_OUT_CREDITS; i < req_ids.size() && !stop_run; i++) begin
            idle_cycles($urandom_range(3));
            out_credit = 1'b1;
            idle_cycles(1);
            out_credit = 1'b0;
            wait_results(i + 1);
        end
        idle_cycles(4);

        if (!stop_run) begin
            if (result_count != req_ids.size() || exp_words.size() != 0) begin
                protocol_errors++;
                $display("Received %0d results for %0d requests", result_count, req_ids.size());
            end
            if (credit_pulses != sent_count || in_credits != `FV_NODE_FIFO_DEPTH) begin
                protocol_errors++;
                $display("Got %0d input credits back for %0d requests",
                         credit_pulses, sent_count);
            end
        end

        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, protocol_errors, timeouts);
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fv_info.f
+incdir+common
common/fv_info_pkg.sv
verilog/node_req_fifo.sv
fv_info_mem/fv_info_memcntl.sv
fv_info_mem/fv_info_sram.sv
verilog/fv_out_fifo.sv
verilog/fv_info_top.sv
sim/fv_info_props.sv
sim/fv_info_tb.sv

//--- build.sh
#!/bin/sh
# Compiles the feature-vector info subsystem with Verilator and runs the testbench.
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing -j 0 \
    --top-module fv_info_tb \
    -f fv_info.f \
    -o fv_info_sim

# The simulator status is not used; the printed result decides.
out=$(./obj_dir/fv_info_sim 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

//--- sim/fv_info_golden.txt
# L node_id word : SRAM load, 12-bit word is line (8 bits) then offset (4 bits)
# R node_id pe_tag : request in send order; E word pe_tag : expected result in order
L 00 0a1
L 01 1b2
L 05 2c3
L 12 3d4
L 2a 4e5
L 3f 5f6
L 40 607
L 7e 718
L 80 829
L a5 93a
L c3 a4b
L ff b5c
R 05 1
R ff 3
R 00 0
R 2a 2
R 80 1
R 12 0
R c3 3
R 05 2
R 3f 1
R 7e 0
R a5 2
R 40 3
E 2c3 1
E b5c 3
E 0a1 0
E 4e5 2
E 829 1
E 3d4 0
E a4b 3
E 2c3 2
E 5f6 1
E 718 0
E 93a 2
E 607 3
